//--- logic/mips_isa_pkg.sv
package mips_isa_pkg;

   // register file indexing
   localparam int NB_REG = 5;
   localparam logic [NB_REG-1:0] REG_LINK = 5'd31; // $ra, target of jal/jalr

   // R-type function field, instr[5:0]
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_SRA  = 6'h03,
      FN_SLLV = 6'h04,
      FN_SRLV = 6'h06,
      FN_SRAV = 6'h07,
      FN_JALR = 6'h09,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_NOR  = 6'h27,
      FN_SLT  = 6'h2a,
      FN_SLTU = 6'h2b
   } funct_e;

   // class handed over by decode
   // immediate classes name their op directly
   typedef enum logic [3:0] {
      CLS_ADD   = 4'd0, // addiu, loads, stores
      CLS_SUB   = 4'd1,
      CLS_RTYPE = 4'd2, // look at funct
      CLS_AND   = 4'd3,
      CLS_OR    = 4'd4,
      CLS_XOR   = 4'd5,
      CLS_SLT   = 4'd6,
      CLS_SLTU  = 4'd7,
      CLS_LUI   = 4'd8,
      CLS_LINK  = 4'd9  // jal, bgezal etc
   } alu_class_e;

   // operations the ALU knows
   typedef enum logic [4:0] {
      OP_ADD    = 5'd0,
      OP_SUB    = 5'd1,
      OP_AND    = 5'd2,
      OP_OR     = 5'd3,
      OP_XOR    = 5'd4,
      OP_NOR    = 5'd5,
      OP_SLT    = 5'd6,
      OP_SLTU   = 5'd7,
      OP_SLL    = 5'd8,
      OP_SRL    = 5'd9,
      OP_SRA    = 5'd10,
      OP_LUI    = 5'd11,
      OP_PASS_A = 5'd12  // link value goes through on A
   } alu_op_e;

endpackage

//--- logic/pipe_ctl_pkg.sv
package pipe_ctl_pkg;

   // operand A source
   typedef enum logic [1:0] {
      A_PC4  = 2'd0,
      A_RS   = 2'd1,
      A_SEXT = 2'd2  // shamt comes in through the immediate
   } a_sel_e;

   // operand B source
   typedef enum logic {
      B_RT   = 1'b0,
      B_SEXT = 1'b1
   } b_sel_e;

   // destination register choice
   typedef enum logic [1:0] {
      DEST_RD   = 2'd0,
      DEST_RT   = 2'd1,
      DEST_LINK = 2'd2
   } dest_sel_e;

   // where an operand value is taken from
   typedef enum logic [1:0] {
      FWD_ID_EX  = 2'd0, // no hazard, value read in decode
      FWD_EX_MEM = 2'd1,
      FWD_MEM_WB = 2'd2
   } fwd_sel_e;

   typedef struct packed {
      logic reg_write;
      logic mem_to_reg;
   } wb_ctl_t;

   typedef struct packed {
      logic       mem_read;
      logic       mem_write;
      logic [1:0] size;          // byte, half, word
      logic       load_unsigned;
   } mem_ctl_t;

   // everything decode hands to EX besides the data words
   typedef struct packed {
      mips_isa_pkg::alu_class_e              alu_class;
      a_sel_e                                a_sel;
      b_sel_e                                b_sel;
      dest_sel_e                             dest_sel;
      mips_isa_pkg::funct_e                  funct;
      logic [mips_isa_pkg::NB_REG-1:0]       rs;
      logic [mips_isa_pkg::NB_REG-1:0]       rt;
      logic [mips_isa_pkg::NB_REG-1:0]       rd;
      wb_ctl_t                               wb;
      mem_ctl_t                              mem;
   } id_ex_ctl_t;

   typedef struct packed {
      wb_ctl_t                               wb;
      mem_ctl_t                              mem;
      logic [mips_isa_pkg::NB_REG-1:0]       reg_dst;
   } ex_mem_ctl_t;

   // what the forward logic needs from MEM/WB
   typedef struct packed {
      logic                                  reg_write;
      logic [mips_isa_pkg::NB_REG-1:0]       reg_dst;
   } wb_fwd_t;

endpackage

//--- logic/alu_control.sv
`timescale 1ns/100ps

module alu_control (
   input  mips_isa_pkg::alu_class_e i_alu_class,
   input  mips_isa_pkg::funct_e     i_funct,
   output mips_isa_pkg::alu_op_e    o_alu_op
);
   import mips_isa_pkg::*;

   alu_op_e rtype_op;

   // R-type, op comes from the function field
   always_comb begin
      case (i_funct)
         FN_SLL,
         FN_SLLV: rtype_op = OP_SLL;   // shift amount already on A
         FN_SRL,
         FN_SRLV: rtype_op = OP_SRL;
         FN_SRA,
         FN_SRAV: rtype_op = OP_SRA;
         FN_ADDU: rtype_op = OP_ADD;
         FN_SUBU: rtype_op = OP_SUB;
         FN_AND:  rtype_op = OP_AND;
         FN_OR:   rtype_op = OP_OR;
         FN_XOR:  rtype_op = OP_XOR;
         FN_NOR:  rtype_op = OP_NOR;
         FN_SLT:  rtype_op = OP_SLT;
         FN_SLTU: rtype_op = OP_SLTU;
         FN_JALR: rtype_op = OP_PASS_A; // return address on A
         default: rtype_op = OP_ADD;
      endcase
   end

   always_comb begin
      case (i_alu_class)
         CLS_ADD:   o_alu_op = OP_ADD;
         CLS_SUB:   o_alu_op = OP_SUB;
         CLS_RTYPE: o_alu_op = rtype_op;
         CLS_AND:   o_alu_op = OP_AND;
         CLS_OR:    o_alu_op = OP_OR;
         CLS_XOR:   o_alu_op = OP_XOR;
         CLS_SLT:   o_alu_op = OP_SLT;
         CLS_SLTU:  o_alu_op = OP_SLTU;
         CLS_LUI:   o_alu_op = OP_LUI;
         CLS_LINK:  o_alu_op = OP_PASS_A;
         default:   o_alu_op = OP_ADD;
      endcase
   end

endmodule

//--- logic/alu.sv
`timescale 1ns/100ps

module alu #(
   parameter int NB_BITS = 32
) (
   input  logic [NB_BITS-1:0]    i_data_a,
   input  logic [NB_BITS-1:0]    i_data_b,
   input  mips_isa_pkg::alu_op_e i_alu_op,
   output logic [NB_BITS-1:0]    o_result
);
   import mips_isa_pkg::*;

   logic [4:0]         shamt;
   logic               lt_signed;
   logic               lt_unsigned;
   logic [NB_BITS-1:0] sum;
   logic [NB_BITS-1:0] diff;

   assign shamt       = i_data_a[4:0];   // shifts move B, amount on A
   assign sum         = i_data_a + i_data_b;
   assign diff        = i_data_a - i_data_b;
   assign lt_signed   = $signed(i_data_a) < $signed(i_data_b);
   assign lt_unsigned = i_data_a < i_data_b;

   always_comb begin
      case (i_alu_op)
         OP_ADD:    o_result = sum;
         OP_SUB:    o_result = diff;
         OP_AND:    o_result = i_data_a & i_data_b;
         OP_OR:     o_result = i_data_a | i_data_b;
         OP_XOR:    o_result = i_data_a ^ i_data_b;
         OP_NOR:    o_result = ~(i_data_a | i_data_b);
         OP_SLT: begin
            o_result = '0;
            o_result[0] = lt_signed;
         end
         OP_SLTU: begin
            o_result = '0;
            o_result[0] = lt_unsigned;
         end
         OP_SLL:    o_result = i_data_b << shamt;
         OP_SRL:    o_result = i_data_b >> shamt;
         OP_SRA:    o_result = $signed(i_data_b) >>> shamt; // keep sign
         OP_LUI:    o_result = i_data_b << 16;             // imm to upper half
         OP_PASS_A: o_result = i_data_a;
         default:   o_result = sum;
      endcase
   end

endmodule

//--- logic/forward_unit.sv
`timescale 1ns/100ps

module forward_unit (
   input  logic [mips_isa_pkg::NB_REG-1:0] i_rs,
   input  logic [mips_isa_pkg::NB_REG-1:0] i_rt,
   input  pipe_ctl_pkg::a_sel_e            i_a_sel,
   input  pipe_ctl_pkg::ex_mem_ctl_t       i_ex_mem,
   input  pipe_ctl_pkg::wb_fwd_t           i_mem_wb,
   output pipe_ctl_pkg::fwd_sel_e          o_fwd_a,
   output pipe_ctl_pkg::fwd_sel_e          o_fwd_b
);
   import mips_isa_pkg::*;
   import pipe_ctl_pkg::*;

   fwd_sel_e rs_src;
   fwd_sel_e rt_src;

   // younger producer first, $zero never forwarded
   function automatic fwd_sel_e pick_src(input logic [NB_REG-1:0] src_reg);
      fwd_sel_e sel;
      sel = FWD_ID_EX;
      if (i_mem_wb.reg_write && (i_mem_wb.reg_dst != '0) &&
          (i_mem_wb.reg_dst == src_reg))
         sel = FWD_MEM_WB;
      if (i_ex_mem.wb.reg_write && (i_ex_mem.reg_dst != '0) &&
          (i_ex_mem.reg_dst == src_reg))
         sel = FWD_EX_MEM;   // overrides MEM/WB
      return sel;
   endfunction

   assign rs_src = pick_src(i_rs);
   assign rt_src = pick_src(i_rt);

   // A only reads a register when it takes rs
   assign o_fwd_a = (i_a_sel == A_RS) ? rs_src : FWD_ID_EX;
   assign o_fwd_b = rt_src;   // also the store data

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/100ps

module execute_stage #(
   parameter int NB_BITS = 32
) (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  pipe_ctl_pkg::id_ex_ctl_t         i_id_ex,
   input  logic [NB_BITS-1:0]               i_rs_data,
   input  logic [NB_BITS-1:0]               i_rt_data,
   input  logic [NB_BITS-1:0]               i_sign_ext,
   input  logic [NB_BITS-1:0]               i_pc_4,
   input  logic [NB_BITS-1:0]               i_mem_wb_data,
   input  pipe_ctl_pkg::fwd_sel_e           i_fwd_a,
   input  pipe_ctl_pkg::fwd_sel_e           i_fwd_b,
   output pipe_ctl_pkg::ex_mem_ctl_t        o_ex_mem,
   output logic [NB_BITS-1:0]               o_alu_result,
   output logic [NB_BITS-1:0]               o_store_data,
   output logic [mips_isa_pkg::NB_REG-1:0]  o_dest_num
);
   import mips_isa_pkg::*;
   import pipe_ctl_pkg::*;

   alu_op_e            alu_op;
   logic [NB_BITS-1:0] a_base;      // before forwarding
   logic [NB_BITS-1:0] data_a;
   logic [NB_BITS-1:0] rt_fwd;      // rt after forwarding
   logic [NB_BITS-1:0] data_b;
   logic [NB_BITS-1:0] alu_out;
   logic [NB_REG-1:0]  dest_num;

   ex_mem_ctl_t        ex_mem_q;
   logic [NB_BITS-1:0] alu_result_q;
   logic [NB_BITS-1:0] store_data_q;

   // EX/MEM feeds back from our own register
   function automatic logic [NB_BITS-1:0] fwd_mux(input fwd_sel_e sel,
                                                  input logic [NB_BITS-1:0] base);
      logic [NB_BITS-1:0] val;
      case (sel)
         FWD_EX_MEM: val = alu_result_q;
         FWD_MEM_WB: val = i_mem_wb_data;
         default:    val = base;
      endcase
      return val;
   endfunction

   always_comb begin
      case (i_id_ex.a_sel)
         A_PC4:   a_base = i_pc_4;     // link value
         A_RS:    a_base = i_rs_data;
         A_SEXT:  a_base = i_sign_ext;
         default: a_base = i_rs_data;
      endcase
   end

   assign data_a = fwd_mux(i_fwd_a, a_base);
   assign rt_fwd = fwd_mux(i_fwd_b, i_rt_data);
   assign data_b = (i_id_ex.b_sel == B_SEXT) ? i_sign_ext : rt_fwd;

   always_comb begin
      case (i_id_ex.dest_sel)
         DEST_RT:   dest_num = i_id_ex.rt;   // I-type
         DEST_LINK: dest_num = REG_LINK;
         default:   dest_num = i_id_ex.rd;
      endcase
   end

   alu_control u_alu_control (
      .i_alu_class (i_id_ex.alu_class),
      .i_funct     (i_id_ex.funct),
      .o_alu_op    (alu_op)
   );

   alu #(
      .NB_BITS (NB_BITS)
   ) u_alu (
      .i_data_a (data_a),
      .i_data_b (data_b),
      .i_alu_op (alu_op),
      .o_result (alu_out)
   );

   // EX/MEM register
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ex_mem_q     <= '0;
         alu_result_q <= '0;
         store_data_q <= '0;
      end else begin
         ex_mem_q.wb      <= i_id_ex.wb;
         ex_mem_q.mem     <= i_id_ex.mem;
         ex_mem_q.reg_dst <= dest_num;
         alu_result_q     <= alu_out;
         store_data_q     <= rt_fwd;   // sw data needs the forwarded rt
      end
   end

   assign o_ex_mem     = ex_mem_q;
   assign o_alu_result = alu_result_q;
   assign o_store_data = store_data_q;
   assign o_dest_num   = dest_num;     // for the stall unit, same cycle

endmodule

//--- logic/exec_subsystem.sv
`timescale 1ns/100ps

module exec_subsystem #(
   parameter int NB_BITS = 32
) (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  pipe_ctl_pkg::id_ex_ctl_t         i_id_ex,
   input  logic [NB_BITS-1:0]               i_rs_data,
   input  logic [NB_BITS-1:0]               i_rt_data,
   input  logic [NB_BITS-1:0]               i_sign_ext,
   input  logic [NB_BITS-1:0]               i_pc_4,
   input  logic [NB_BITS-1:0]               i_mem_wb_data,
   input  pipe_ctl_pkg::wb_fwd_t            i_mem_wb,
   output pipe_ctl_pkg::ex_mem_ctl_t        o_ex_mem,
   output logic [NB_BITS-1:0]               o_alu_result,
   output logic [NB_BITS-1:0]               o_store_data,
   output logic [mips_isa_pkg::NB_REG-1:0]  o_dest_num
);
   import pipe_ctl_pkg::*;

   fwd_sel_e fwd_a;
   fwd_sel_e fwd_b;

   // hazard side, compares against the EX/MEM register below
   forward_unit u_forward_unit (
      .i_rs     (i_id_ex.rs),
      .i_rt     (i_id_ex.rt),
      .i_a_sel  (i_id_ex.a_sel),
      .i_ex_mem (o_ex_mem),
      .i_mem_wb (i_mem_wb),
      .o_fwd_a  (fwd_a),
      .o_fwd_b  (fwd_b)
   );

   execute_stage #(
      .NB_BITS (NB_BITS)
   ) u_execute_stage (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_id_ex       (i_id_ex),
      .i_rs_data     (i_rs_data),
      .i_rt_data     (i_rt_data),
      .i_sign_ext    (i_sign_ext),
      .i_pc_4        (i_pc_4),
      .i_mem_wb_data (i_mem_wb_data),
      .i_fwd_a       (fwd_a),
      .i_fwd_b       (fwd_b),
      .o_ex_mem      (o_ex_mem),
      .o_alu_result  (o_alu_result),
      .o_store_data  (o_store_data),
      .o_dest_num    (o_dest_num)
   );

endmodule

//--- tb/exec_tb.sv
`timescale 1ns/100ps

module exec_tb;
   import mips_isa_pkg::*;
   import pipe_ctl_pkg::*;

   localparam int NB_BITS     = 32;
   localparam int CYCLE_LIMIT = 400;   // tests use about 50 cycles
   localparam funct_e RTYPE_FNS [15] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV,
      FN_SRAV, FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU, FN_JALR};
   localparam alu_class_e IMM_CLASSES [8] = '{CLS_ADD, CLS_SUB, CLS_AND, CLS_OR,
      CLS_XOR, CLS_SLT, CLS_SLTU, CLS_LUI};

   logic               i_clk;
   logic               i_rst;
   id_ex_ctl_t         i_id_ex;
   logic [NB_BITS-1:0] i_rs_data;
   logic [NB_BITS-1:0] i_rt_data;
   logic [NB_BITS-1:0] i_sign_ext;
   logic [NB_BITS-1:0] i_pc_4;
   logic [NB_BITS-1:0] i_mem_wb_data;
   wb_fwd_t            i_mem_wb;
   ex_mem_ctl_t        o_ex_mem;
   logic [NB_BITS-1:0] o_alu_result;
   logic [NB_BITS-1:0] o_store_data;
   logic [NB_REG-1:0]  o_dest_num;

   // model of the EX/MEM register
   ex_mem_ctl_t        model_ctl;
   logic [NB_BITS-1:0] model_result;
   logic [NB_BITS-1:0] model_store;

   integer seed   = 32'hfe93_b887;
   int     checks = 0;
   int     errors = 0;
   int     cycles = 0;

   exec_subsystem #(
      .NB_BITS (NB_BITS)
   ) u_exec_subsystem (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_id_ex       (i_id_ex),
      .i_rs_data     (i_rs_data),
      .i_rt_data     (i_rt_data),
      .i_sign_ext    (i_sign_ext),
      .i_pc_4        (i_pc_4),
      .i_mem_wb_data (i_mem_wb_data),
      .i_mem_wb      (i_mem_wb),
      .o_ex_mem      (o_ex_mem),
      .o_alu_result  (o_alu_result),
      .o_store_data  (o_store_data),
      .o_dest_num    (o_dest_num)
   );

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic check_word(input string name, input logic [NB_BITS-1:0] got,
                             input logic [NB_BITS-1:0] exp);
      checks++;
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_ex_mem(input string name, input ex_mem_ctl_t got,
                               input ex_mem_ctl_t exp);
      checks++;
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_index(input string name, input logic [NB_REG-1:0] got,
                              input logic [NB_REG-1:0] exp);
      checks++;
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("%s: %s", name, (errors == errs_before) ? "ok" : "mismatches found");
   endtask

   function automatic logic [NB_BITS-1:0] rand_word();
      return $random(seed);
   endfunction

   // ALU behaviour as the instruction set defines it
   function automatic logic [NB_BITS-1:0] ref_alu(input alu_class_e cls, input funct_e fn,
                                                  input logic [NB_BITS-1:0] a,
                                                  input logic [NB_BITS-1:0] b);
      logic [4:0]         sh;
      logic [NB_BITS-1:0] r;
      sh = a[4:0];
      r  = a + b;   // add, and anything unknown
      case (cls)
         CLS_SUB:  r = a - b;
         CLS_AND:  r = a & b;
         CLS_OR:   r = a | b;
         CLS_XOR:  r = a ^ b;
         CLS_SLT:  r = {{(NB_BITS-1){1'b0}}, $signed(a) < $signed(b)};
         CLS_SLTU: r = {{(NB_BITS-1){1'b0}}, a < b};
         CLS_LUI:  r = {b[NB_BITS-17:0], 16'h0000};
         CLS_LINK: r = a;
         CLS_RTYPE: begin
            case (fn)
               FN_SLL, FN_SLLV: r = b << sh;
               FN_SRL, FN_SRLV: r = b >> sh;
               FN_SRA, FN_SRAV:   // fill vacated bits with the sign
                  r = (b >> sh) | (b[NB_BITS-1] ? ~({NB_BITS{1'b1}} >> sh) : {NB_BITS{1'b0}});
               FN_SUBU: r = a - b;
               FN_AND:  r = a & b;
               FN_OR:   r = a | b;
               FN_XOR:  r = a ^ b;
               FN_NOR:  r = ~(a | b);
               FN_SLT:  r = {{(NB_BITS-1){1'b0}}, $signed(a) < $signed(b)};
               FN_SLTU: r = {{(NB_BITS-1){1'b0}}, a < b};
               FN_JALR: r = a;
               default: r = a + b;
            endcase
         end
         default: r = a + b;
      endcase
      return r;
   endfunction

   // newest producer first, never r0, never a non-writing one
   function automatic logic [NB_BITS-1:0] pick_operand(input logic [NB_REG-1:0] src,
                                                       input logic [NB_BITS-1:0] base);
      if (model_ctl.wb.reg_write && (src != '0) && (model_ctl.reg_dst == src))
         return model_result;
      if (i_mem_wb.reg_write && (src != '0) && (i_mem_wb.reg_dst == src))
         return i_mem_wb_data;
      return base;
   endfunction

   function automatic id_ex_ctl_t make_ctl(input alu_class_e cls, input a_sel_e a_sel,
                                           input b_sel_e b_sel, input dest_sel_e dest_sel,
                                           input funct_e fn, input logic [NB_REG-1:0] rs,
                                           input logic [NB_REG-1:0] rt,
                                           input logic [NB_REG-1:0] rd);
      id_ex_ctl_t c;
      c              = '0;
      c.alu_class    = cls;
      c.a_sel        = a_sel;
      c.b_sel        = b_sel;
      c.dest_sel     = dest_sel;
      c.funct        = fn;
      c.rs           = rs;
      c.rt           = rt;
      c.rd           = rd;
      c.wb.reg_write = 1'b1;
      return c;
   endfunction

   task automatic set_mem_wb(input logic we, input logic [NB_REG-1:0] dst,
                             input logic [NB_BITS-1:0] data);
      i_mem_wb.reg_write = we;
      i_mem_wb.reg_dst   = dst;
      i_mem_wb_data      = data;
   endtask

   // drive one instruction at a falling edge, check it at the next one
   task automatic issue(input id_ex_ctl_t ctl, input logic [NB_BITS-1:0] rs_d,
                        input logic [NB_BITS-1:0] rt_d, input logic [NB_BITS-1:0] imm,
                        input logic [NB_BITS-1:0] pc4);
      logic [NB_BITS-1:0] a_val;
      logic [NB_BITS-1:0] rt_val;
      logic [NB_BITS-1:0] b_val;
      logic [NB_BITS-1:0] result;
      ex_mem_ctl_t        next_ctl;
      i_id_ex    = ctl;
      i_rs_data  = rs_d;
      i_rt_data  = rt_d;
      i_sign_ext = imm;
      i_pc_4     = pc4;
      case (ctl.a_sel)
         A_PC4:   a_val = pc4;
         A_SEXT:  a_val = imm;
         default: a_val = pick_operand(ctl.rs, rs_d);
      endcase
      rt_val = pick_operand(ctl.rt, rt_d);
      b_val  = (ctl.b_sel == B_SEXT) ? imm : rt_val;
      result = ref_alu(ctl.alu_class, ctl.funct, a_val, b_val);
      next_ctl.wb  = ctl.wb;
      next_ctl.mem = ctl.mem;
      case (ctl.dest_sel)
         DEST_RT:   next_ctl.reg_dst = ctl.rt;
         DEST_LINK: next_ctl.reg_dst = REG_LINK;
         default:   next_ctl.reg_dst = ctl.rd;
      endcase
      #1;
      check_index("o_dest_num", o_dest_num, next_ctl.reg_dst);
      @(negedge i_clk);
      model_ctl    = next_ctl;
      model_result = result;
      model_store  = rt_val;
      check_ex_mem("o_ex_mem", o_ex_mem, model_ctl);
      check_word("o_alu_result", o_alu_result, model_result);
      check_word("o_store_data", o_store_data, model_store);
   endtask

   task automatic reset_sequence();
      int         errs0;
      id_ex_ctl_t ctl;
      errs0 = errors;
      // live instruction on the inputs while reset is held
      ctl        = make_ctl(CLS_OR, A_RS, B_RT, DEST_RD, FN_ADDU, 5'd1, 5'd2, 5'd3);
      ctl.wb     = '1;
      ctl.mem    = '1;
      i_id_ex    = ctl;
      i_rs_data  = rand_word();
      i_rt_data  = rand_word();
      i_sign_ext = rand_word();
      i_pc_4     = rand_word();
      i_rst = 1'b1;
      repeat (5) @(posedge i_clk);
      @(negedge i_clk);
      model_ctl    = '0;
      model_result = '0;
      model_store  = '0;
      check_ex_mem("o_ex_mem", o_ex_mem, model_ctl);
      check_word("o_alu_result", o_alu_result, model_result);
      check_word("o_store_data", o_store_data, model_store);
      i_rst = 1'b0;
      report_test("reset", errs0);
   endtask

   task automatic rtype_ops();
      int          errs0;
      logic [31:0] rnd;
      a_sel_e      a_sel;
      funct_e      fn;
      errs0 = errors;
      for (int i = 0; i < 15; i++) begin
         rnd = rand_word();
         fn  = RTYPE_FNS[i];
         if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA)
            a_sel = A_SEXT;   // shamt through the immediate
         else if (fn == FN_JALR)
            a_sel = A_PC4;
         else
            a_sel = A_RS;
         issue(make_ctl(CLS_RTYPE, a_sel, B_RT, DEST_RD, fn, rnd[4:0], rnd[9:5], rnd[14:10]),
               rand_word(), rand_word(), rand_word(), rand_word());
      end
      report_test("r-type ops", errs0);
   endtask

   task automatic immediate_ops();
      int          errs0;
      logic [31:0] rnd;
      id_ex_ctl_t  ctl;
      errs0 = errors;
      for (int i = 0; i < 8; i++) begin
         rnd = rand_word();
         ctl = make_ctl(IMM_CLASSES[i], A_RS, B_SEXT, DEST_RT, FN_ADDU,
                        rnd[4:0], rnd[9:5], rnd[14:10]);
         issue(ctl, rand_word(), rand_word(), rand_word(), rand_word());
      end
      // store word, address is rs + imm
      rnd = rand_word();
      ctl = make_ctl(CLS_ADD, A_RS, B_SEXT, DEST_RT, FN_ADDU, rnd[4:0], rnd[9:5], 5'd0);
      ctl.wb.reg_write = 1'b0;
      ctl.mem.mem_write = 1'b1;
      ctl.mem.size = 2'd2;
      issue(ctl, rand_word(), rand_word(), rand_word(), rand_word());
      // load halfword unsigned
      ctl = make_ctl(CLS_ADD, A_RS, B_SEXT, DEST_RT, FN_ADDU, rnd[14:10], rnd[19:15], 5'd0);
      ctl.wb.mem_to_reg = 1'b1;
      ctl.mem.mem_read = 1'b1;
      ctl.mem.size = 2'd1;
      ctl.mem.load_unsigned = 1'b1;
      issue(ctl, rand_word(), rand_word(), rand_word(), rand_word());
      report_test("immediates and memory", errs0);
   endtask

   task automatic forwarding_paths();
      int         errs0;
      id_ex_ctl_t ctl;
      errs0 = errors;
      set_mem_wb(1'b0, 5'd0, rand_word());
      issue(make_ctl(CLS_RTYPE, A_RS, B_RT, DEST_RD, FN_ADDU, 5'd1, 5'd2, 5'd5),
            rand_word(), rand_word(), rand_word(), rand_word());
      // r5 on both sides from EX/MEM
      issue(make_ctl(CLS_RTYPE, A_RS, B_RT, DEST_RD, FN_SUBU, 5'd5, 5'd5, 5'd6),
            rand_word(), rand_word(), rand_word(), rand_word());
      set_mem_wb(1'b1, 5'd7, rand_word());
      issue(make_ctl(CLS_RTYPE, A_RS, B_RT, DEST_RD, FN_XOR, 5'd7, 5'd3, 5'd8),
            rand_word(), rand_word(), rand_word(), rand_word());
      // r7 pending in both EX/MEM and MEM/WB
      issue(make_ctl(CLS_RTYPE, A_RS, B_RT, DEST_RD, FN_OR, 5'd1, 5'd2, 5'd7),
            rand_word(), rand_word(), rand_word(), rand_word());
      issue(make_ctl(CLS_RTYPE, A_RS, B_RT, DEST_RD, FN_ADDU, 5'd7, 5'd7, 5'd9),
            rand_word(), rand_word(), rand_word(), rand_word());
      // writes to r0 stay invisible
      issue(make_ctl(CLS_RTYPE, A_RS, B_RT, DEST_RD, FN_ADDU, 5'd1, 5'd2, 5'd0),
            rand_word(), rand_word(), rand_word(), rand_word());
      set_mem_wb(1'b1, 5'd0, rand_word());
      issue(make_ctl(CLS_RTYPE, A_RS, B_RT, DEST_RD, FN_AND, 5'd0, 5'd0, 5'd10),
            rand_word(), rand_word(), rand_word(), rand_word());
      // store and idle MEM/WB both name r12 without writing it
      ctl = make_ctl(CLS_ADD, A_RS, B_SEXT, DEST_RT, FN_ADDU, 5'd1, 5'd12, 5'd0);
      ctl.wb.reg_write = 1'b0;
      ctl.mem.mem_write = 1'b1;
      set_mem_wb(1'b0, 5'd12, rand_word());
      issue(ctl, rand_word(), rand_word(), rand_word(), rand_word());
      issue(make_ctl(CLS_RTYPE, A_RS, B_RT, DEST_RD, FN_ADDU, 5'd12, 5'd12, 5'd13),
            rand_word(), rand_word(), rand_word(), rand_word());
      // store right after its data producer
      issue(make_ctl(CLS_RTYPE, A_RS, B_RT, DEST_RD, FN_NOR, 5'd3, 5'd4, 5'd14),
            rand_word(), rand_word(), rand_word(), rand_word());
      ctl = make_ctl(CLS_ADD, A_RS, B_SEXT, DEST_RT, FN_ADDU, 5'd14, 5'd14, 5'd0);
      ctl.wb.reg_write = 1'b0;
      ctl.mem.mem_write = 1'b1;
      issue(ctl, rand_word(), rand_word(), rand_word(), rand_word());
      set_mem_wb(1'b0, 5'd0, '0);
      report_test("forwarding", errs0);
   endtask

   task automatic link_ops();
      int          errs0;
      logic [31:0] rnd;
      errs0 = errors;
      rnd = rand_word();
      issue(make_ctl(CLS_LINK, A_PC4, B_RT, DEST_LINK, FN_ADDU, rnd[4:0], rnd[9:5], rnd[14:10]),
            rand_word(), rand_word(), rand_word(), rand_word());
      // rs names the $ra just written, yet A stays on PC+4
      issue(make_ctl(CLS_RTYPE, A_PC4, B_RT, DEST_RD, FN_JALR, REG_LINK, 5'd0, REG_LINK),
            rand_word(), rand_word(), rand_word(), rand_word());
      report_test("link", errs0);
   endtask

   initial begin
      i_rst         = 1'b1;
      i_id_ex       = '0;
      i_rs_data     = '0;
      i_rt_data     = '0;
      i_sign_ext    = '0;
      i_pc_4        = '0;
      i_mem_wb_data = '0;
      i_mem_wb      = '0;
      model_ctl     = '0;
      model_result  = '0;
      model_store   = '0;
      reset_sequence();
      rtype_ops();
      immediate_ops();
      forwarding_paths();
      link_ops();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- exec_subsystem.f
logic/mips_isa_pkg.sv
logic/pipe_ctl_pkg.sv
logic/alu_control.sv
logic/alu.sv
logic/forward_unit.sv
logic/execute_stage.sv
logic/exec_subsystem.sv
tb/exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing -f exec_subsystem.f --top-module exec_tb -o exec_sim &&
./obj_dir/exec_sim | tee /dev/stderr | grep -q "All checks passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
